// File: src/kbd_cfg.svh
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard receiver configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Equal clk samples needed before a new ps2_clk level is taken
`define KBD_FILTER_LEN 4

// Entries in the event queue ahead of the output stage
`define KBD_QUEUE_DEPTH 4

// Credits held by the receiver after reset
`define KBD_CREDITS 2

// Press counter width, wraps at the top
`define KBD_COUNT_W 8

`endif

// File: src/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

	// Raw set-2 scancode byte
	typedef logic [7:0] scancode_t;

	// Lower case ASCII, zero when there is no mapping
	typedef logic [7:0] ascii_t;

	// One PS/2 frame as it sits in the shift register, stop bit on top
	typedef struct packed {
		logic      stop;
		logic      parity;
		scancode_t data;
		logic      start;
	} ps2_fields_t;

	// Shifted in as raw bits, checked as fields
	typedef union packed {
		logic [10:0] raw;
		ps2_fields_t fields;
	} ps2_frame_u;

	// Prefix bytes that modify the following code
	typedef enum logic [7:0] {
		PFX_EXT   = 8'hE0,
		PFX_BREAK = 8'hF0
	} code_prefix_e;

endpackage

`default_nettype wire

// File: src/kbd_event_if.sv
`default_nettype none

// Decoded key events, one strobe per non-prefix byte
interface kbd_event_if;
	import kbd_pkg::*;

	logic      valid;
	scancode_t code;
	logic      is_break;
	logic      is_ext;

	modport sender (
		output valid,
		output code,
		output is_break,
		output is_ext
	);

	modport receiver (
		input valid,
		input code,
		input is_break,
		input is_ext
	);

endinterface

`default_nettype wire

// File: src/ps2_frame_rx.sv
`default_nettype none

`include "kbd_cfg.svh"

module ps2_frame_rx (
	input  logic               clk,
	input  logic               resetn,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	output logic               byte_valid,
	output kbd_pkg::scancode_t byte_data,
	output logic               frame_err
);
	import kbd_pkg::*;

	localparam int FILT_W = $clog2(`KBD_FILTER_LEN) + 1;

	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic              clk_filt;
	logic [FILT_W-1:0] filt_cnt;
	logic              fall;
	logic [3:0]        bit_cnt;
	logic [10:0]       idle_cnt;
	ps2_frame_u        frame;
	ps2_frame_u        frame_next;
	logic              frame_ok;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Synchronise and filter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Both lines idle high
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_filt <= 1'b1;
			filt_cnt <= '0;
		end else if (clk_sync[1] == clk_filt) begin
			filt_cnt <= '0;
		end else if (filt_cnt == FILT_W'(`KBD_FILTER_LEN - 1)) begin
			clk_filt <= clk_sync[1];
			filt_cnt <= '0;
		end else begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	// Falling edge taken in the same cycle the filter accepts the low level
	assign fall = clk_filt && !clk_sync[1] && (filt_cnt == FILT_W'(`KBD_FILTER_LEN - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift and check
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// LSB first, so new bits enter at the top
	always_comb begin
		frame_next.raw = {data_sync[1], frame.raw[10:1]};
		frame_ok = (frame_next.fields.start == 1'b0) && frame_next.fields.stop &&
			(^{frame_next.fields.data, frame_next.fields.parity});
	end

	always_ff @(posedge clk) begin
		if (fall) begin
			frame <= frame_next;
		end
		if (fall && bit_cnt == 4'd10) begin
			byte_data <= frame_next.fields.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt    <= '0;
			idle_cnt   <= '0;
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					byte_valid <= frame_ok;
					frame_err  <= !frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0 && clk_filt) begin
				// Partial frame abandoned after a long idle
				if (idle_cnt == 11'd2047) begin
					bit_cnt  <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 11'd1;
				end
			end
		end
	end

	// One single-cycle result per frame
	a_one_result: assert property (@(posedge clk) disable iff (!resetn)
		(byte_valid || frame_err) |=> !(byte_valid || frame_err));

endmodule

`default_nettype wire

// File: src/scancode_decoder.sv
`default_nettype none

module scancode_decoder (
	input  logic               clk,
	input  logic               resetn,
	input  logic               byte_valid,
	input  kbd_pkg::scancode_t byte_data,
	kbd_event_if.sender        ev
);
	import kbd_pkg::*;

	logic brk_pend;
	logic ext_pend;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Prefix tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!resetn) begin
			brk_pend <= 1'b0;
			ext_pend <= 1'b0;
			ev.valid <= 1'b0;
		end else begin
			ev.valid <= 1'b0;
			if (byte_valid) begin
				if (byte_data == PFX_EXT) begin
					ext_pend <= 1'b1;
				end else if (byte_data == PFX_BREAK) begin
					brk_pend <= 1'b1;
				end else begin
					// Flags belong to this code only
					ev.valid <= 1'b1;
					brk_pend <= 1'b0;
					ext_pend <= 1'b0;
				end
			end
		end
	end

	// Event payload
	always_ff @(posedge clk) begin
		if (byte_valid && byte_data != PFX_EXT && byte_data != PFX_BREAK) begin
			ev.code     <= byte_data;
			ev.is_break <= brk_pend;
			ev.is_ext   <= ext_pend;
		end
	end

endmodule

`default_nettype wire

// File: src/ascii_map.sv
`default_nettype none

module ascii_map (
	input  logic               clk,
	input  kbd_pkg::scancode_t code,
	output kbd_pkg::ascii_t    ascii
);

	// Set-2 make codes, lower case only
	always_ff @(posedge clk) begin
		case (code)
			8'h1C: ascii <= 8'h61;
			8'h32: ascii <= 8'h62;
			8'h21: ascii <= 8'h63;
			8'h23: ascii <= 8'h64;
			8'h24: ascii <= 8'h65;
			8'h2B: ascii <= 8'h66;
			8'h34: ascii <= 8'h67;
			8'h33: ascii <= 8'h68;
			8'h43: ascii <= 8'h69;
			8'h3B: ascii <= 8'h6A;
			8'h42: ascii <= 8'h6B;
			8'h4B: ascii <= 8'h6C;
			8'h3A: ascii <= 8'h6D;
			8'h31: ascii <= 8'h6E;
			8'h44: ascii <= 8'h6F;
			8'h4D: ascii <= 8'h70;
			8'h15: ascii <= 8'h71;
			8'h2D: ascii <= 8'h72;
			8'h1B: ascii <= 8'h73;
			8'h2C: ascii <= 8'h74;
			8'h3C: ascii <= 8'h75;
			8'h2A: ascii <= 8'h76;
			8'h1D: ascii <= 8'h77;
			8'h22: ascii <= 8'h78;
			8'h35: ascii <= 8'h79;
			8'h1A: ascii <= 8'h7A;
			// Main row digits
			8'h45: ascii <= 8'h30;
			8'h16: ascii <= 8'h31;
			8'h1E: ascii <= 8'h32;
			8'h26: ascii <= 8'h33;
			8'h25: ascii <= 8'h34;
			8'h2E: ascii <= 8'h35;
			8'h36: ascii <= 8'h36;
			8'h3D: ascii <= 8'h37;
			8'h3E: ascii <= 8'h38;
			8'h46: ascii <= 8'h39;
			// Whitespace and editing keys
			8'h29: ascii <= 8'h20;
			8'h5A: ascii <= 8'h0D;
			8'h66: ascii <= 8'h08;
			8'h0D: ascii <= 8'h09;
			default: ascii <= 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: src/kbd_ctrl.sv
`default_nettype none

`include "kbd_cfg.svh"

module kbd_ctrl (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    frame_err,
	kbd_event_if.receiver           ev,
	output kbd_pkg::scancode_t      map_code,
	input  kbd_pkg::ascii_t         map_ascii,
	input  logic                    ev_credit,
	output logic                    ev_valid,
	output kbd_pkg::scancode_t      ev_scancode,
	output kbd_pkg::ascii_t         ev_ascii,
	output logic                    ev_release,
	output logic                    ev_extended,
	output logic                    frame_error,
	output logic                    overflow,
	output logic [`KBD_COUNT_W-1:0] press_count
);
	import kbd_pkg::*;

	localparam int DEPTH  = `KBD_QUEUE_DEPTH;
	localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam int CRED_W = $clog2(`KBD_CREDITS + 1) + 1;

	logic              held_valid;
	scancode_t         held_code;
	logic              held_ext;
	logic              held_match;
	logic              accept;

	scancode_t         q_code [DEPTH];
	logic              q_brk  [DEPTH];
	logic              q_ext  [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  q_cnt;
	logic              q_empty;
	logic              q_full;
	logic              push;
	logic              pop;

	logic [CRED_W-1:0] credit_cnt;
	logic [CRED_W-1:0] in_flight;
	logic              s1_valid;
	scancode_t         s1_code;
	logic              s1_brk;
	logic              s1_ext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Held key and repeat filter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign held_match = held_valid && (ev.code == held_code) && (ev.is_ext == held_ext);
	// Typematic repeats of the held key go no further
	assign accept     = ev.valid && (ev.is_break || !held_match);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			held_valid  <= 1'b0;
			press_count <= '0;
		end else if (ev.valid) begin
			if (!ev.is_break && !held_match) begin
				held_valid  <= 1'b1;
				press_count <= press_count + 1'b1;
			end else if (ev.is_break && held_match) begin
				held_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ev.valid && !ev.is_break) begin
			held_code <= ev.code;
			held_ext  <= ev.is_ext;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Event queue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign q_empty   = (q_cnt == '0);
	assign q_full    = (q_cnt == CNT_W'(DEPTH));
	assign push      = accept && !q_full;
	assign in_flight = CRED_W'(s1_valid) + CRED_W'(ev_valid);
	// Keep a credit in hand for everything already past the head
	assign pop       = !q_empty && (credit_cnt > in_flight);
	assign map_code  = q_code[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			q_code[wr_ptr] <= ev.code;
			q_brk[wr_ptr]  <= ev.is_break;
			q_ext[wr_ptr]  <= ev.is_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			q_cnt    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: q_cnt <= q_cnt + 1'b1;
				2'b01: q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
			if (accept && q_full) begin
				overflow <= 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Credits and output path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!resetn) begin
			credit_cnt  <= CRED_W'(`KBD_CREDITS);
			s1_valid    <= 1'b0;
			ev_valid    <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			case ({ev_credit, ev_valid})
				2'b10: credit_cnt <= credit_cnt + 1'b1;
				2'b01: credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			s1_valid    <= pop;
			ev_valid    <= s1_valid;
			frame_error <= frame_err;
		end
	end

	// Lookup runs in parallel with stage 1
	always_ff @(posedge clk) begin
		s1_code     <= map_code;
		s1_brk      <= q_brk[rd_ptr];
		s1_ext      <= q_ext[rd_ptr];
		ev_scancode <= s1_code;
		ev_release  <= s1_brk;
		ev_extended <= s1_ext;
		ev_ascii    <= s1_ext ? '0 : map_ascii;
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!resetn)
		credit_cnt <= CRED_W'(`KBD_CREDITS));

	a_credit_spend: assert property (@(posedge clk) disable iff (!resetn)
		ev_valid |-> credit_cnt != '0);

	// Pointers must show a stored entry whenever the head is taken
	a_pop_nonempty: assert property (@(posedge clk) disable iff (!resetn)
		pop |-> (wr_ptr != rd_ptr) || q_full);

endmodule

`default_nettype wire

// File: src/ps2_kbd_top.sv
`default_nettype none

`include "kbd_cfg.svh"

module ps2_kbd_top (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    ps2_clk,
	input  logic                    ps2_data,
	input  logic                    ev_credit,
	output logic                    ev_valid,
	output kbd_pkg::scancode_t      ev_scancode,
	output kbd_pkg::ascii_t         ev_ascii,
	output logic                    ev_release,
	output logic                    ev_extended,
	output logic [`KBD_COUNT_W-1:0] press_count,
	output logic                    frame_error,
	output logic                    overflow
);
	import kbd_pkg::*;

	logic      byte_valid;
	scancode_t byte_data;
	logic      frame_err;
	scancode_t map_code;
	ascii_t    map_ascii;

	kbd_event_if ev_link ();

	ps2_frame_rx u_frame_rx (
		.clk        (clk),
		.resetn     (resetn),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.frame_err  (frame_err)
	);

	scancode_decoder u_decoder (
		.clk        (clk),
		.resetn     (resetn),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.ev         (ev_link.sender)
	);

	ascii_map u_ascii_map (
		.clk   (clk),
		.code  (map_code),
		.ascii (map_ascii)
	);

	kbd_ctrl u_ctrl (
		.clk         (clk),
		.resetn      (resetn),
		.frame_err   (frame_err),
		.ev          (ev_link.receiver),
		.map_code    (map_code),
		.map_ascii   (map_ascii),
		.ev_credit   (ev_credit),
		.ev_valid    (ev_valid),
		.ev_scancode (ev_scancode),
		.ev_ascii    (ev_ascii),
		.ev_release  (ev_release),
		.ev_extended (ev_extended),
		.frame_error (frame_error),
		.overflow    (overflow),
		.press_count (press_count)
	);

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held for five cycles, released on a falling edge
	initial begin
		resetn = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/tb_ps2_kbd.sv
`default_nettype none

`include "kbd_cfg.svh"

module tb_ps2_kbd;
	import kbd_pkg::*;

	typedef struct packed {
		scancode_t code;
		ascii_t    ascii;
		logic      rel;
		logic      ext;
	} exp_t;

	logic                    clk;
	logic                    resetn;
	logic                    ps2_clk;
	logic                    ps2_data;
	logic                    ev_credit = 1'b0;
	logic                    ev_valid;
	scancode_t               ev_scancode;
	ascii_t                  ev_ascii;
	logic                    ev_release;
	logic                    ev_extended;
	logic [`KBD_COUNT_W-1:0] press_count;
	logic                    frame_error;
	logic                    overflow;

	integer seed = 32'h9a30;
	integer credit_seed = 32'h9a30 + 1;

	string  test_name = "reset";
	exp_t   exp_q [$];
	exp_t   head;
	int     delivered = 0;
	int     returned = 0;
	int     frame_err_seen = 0;
	logic   credit_en = 1'b1;

	// Reference state for the held key and the press counter
	logic                    model_held_valid = 1'b0;
	scancode_t               model_held_code = '0;
	logic                    model_held_ext = 1'b0;
	logic [`KBD_COUNT_W-1:0] model_count = '0;

	scancode_t letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
		8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
	scancode_t digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
		8'h3D, 8'h3E, 8'h46};
	scancode_t special_codes [4] = '{8'h29, 8'h5A, 8'h66, 8'h0D};
	ascii_t    special_ascii [4] = '{8'h20, 8'h0D, 8'h08, 8'h09};
	// Esc, F1, shifts, ctrl, alt
	scancode_t unmapped_codes [6] = '{8'h76, 8'h05, 8'h12, 8'h59, 8'h14, 8'h11};

	tb_clk_gen u_clk_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	ps2_kbd_top dut (
		.clk         (clk),
		.resetn      (resetn),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.ev_credit   (ev_credit),
		.ev_valid    (ev_valid),
		.ev_scancode (ev_scancode),
		.ev_ascii    (ev_ascii),
		.ev_release  (ev_release),
		.ev_extended (ev_extended),
		.press_count (press_count),
		.frame_error (frame_error),
		.overflow    (overflow)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting and compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_code(input string what, input scancode_t exp, input scancode_t act);
		if (exp !== act) begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ascii(input string what, input ascii_t exp, input ascii_t act);
		if (exp !== act) begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input logic [`KBD_COUNT_W-1:0] exp,
		input logic [`KBD_COUNT_W-1:0] act);
		if (exp !== act) begin
			$display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic ascii_t ref_ascii(input scancode_t code, input logic ext);
		ascii_t a;
		int     k;
		a = 8'h00;
		if (!ext) begin
			for (k = 0; k < 26; k++)
				if (letter_codes[k] == code) a = ascii_t'(8'h61 + k);
			for (k = 0; k < 10; k++)
				if (digit_codes[k] == code) a = ascii_t'(8'h30 + k);
			for (k = 0; k < 4; k++)
				if (special_codes[k] == code) a = special_ascii[k];
		end
		return a;
	endfunction

	// Mostly mapped codes, some without an ASCII value
	function automatic scancode_t pick_code();
		int r;
		r = $unsigned($random(seed)) % 8;
		case (r)
			0, 1, 2, 3: return letter_codes[$unsigned($random(seed)) % 26];
			4: return digit_codes[$unsigned($random(seed)) % 10];
			5: return special_codes[$unsigned($random(seed)) % 4];
			default: return unmapped_codes[$unsigned($random(seed)) % 6];
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PS/2 device model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic send_byte(input scancode_t data, input logic bad_par, input logic bad_stop);
		logic [10:0] bits;
		int          i;
		bits = {~bad_stop, (~^data) ^ bad_par, data, 1'b0};
		wait_cycles(1);
		for (i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			wait_cycles(10);
			ps2_clk = 1'b0;
			wait_cycles(10);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		wait_cycles(20);
	endtask

	// Expected event goes in before the code byte so it is never late
	task automatic key_event(input scancode_t code, input logic brk, input logic ext,
		input logic lost);
		exp_t e;
		logic match;
		match = model_held_valid && model_held_code == code && model_held_ext == ext;
		if (!brk && !match) begin
			model_held_valid = 1'b1;
			model_held_code  = code;
			model_held_ext   = ext;
			model_count      = model_count + 1'b1;
		end else if (brk && match) begin
			model_held_valid = 1'b0;
		end
		if ((brk || !match) && !lost) begin
			e.code  = code;
			e.ascii = ref_ascii(code, ext);
			e.rel   = brk;
			e.ext   = ext;
			exp_q.push_back(e);
		end
		if (ext) send_byte(PFX_EXT, 1'b0, 1'b0);
		if (brk) send_byte(PFX_BREAK, 1'b0, 1'b0);
		send_byte(code, 1'b0, 1'b0);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("No event arrived within 2000 cycles in %s", test_name);
			abort_run();
		end
		n = 0;
		while (delivered != returned && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (delivered != returned) begin
			$display("Credits were not all returned within 2000 cycles in %s", test_name);
			abort_run();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output monitor and consumer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		ev_credit = 1'b0;
		if (resetn) begin
			if (frame_error) frame_err_seen++;
			if (ev_valid) begin
				delivered++;
				if (delivered > `KBD_CREDITS + returned) begin
					$display("More events were delivered than credits allow in %s",
						test_name);
					abort_run();
				end
				if (exp_q.size() == 0) begin
					$display("An event arrived when none was expected in %s", test_name);
					abort_run();
				end
				head = exp_q.pop_front();
				check_code("scancode", head.code, ev_scancode);
				check_ascii("ascii", head.ascii, ev_ascii);
				check_flag("release", head.rel, ev_release);
				check_flag("extended", head.ext, ev_extended);
			end
			// Random credit return, never more than used
			if (credit_en && delivered > returned && ($random(credit_seed) & 7) == 0) begin
				ev_credit = 1'b1;
				returned++;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int        i;
		int        n;
		int        kind;
		int        errs_before;
		logic      ext;
		logic      stall;
		logic      prev_stall;
		scancode_t code;

		ps2_clk  = 1'b1;
		ps2_data = 1'b1;

		n = 0;
		while (!resetn && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!resetn) begin
			$display("Reset was never released");
			abort_run();
		end
		wait_cycles(2);
		check_flag("ev_valid", 1'b0, ev_valid);
		check_flag("frame_error", 1'b0, frame_error);
		check_flag("overflow", 1'b0, overflow);
		check_count("press_count", '0, press_count);

		test_name = "make_break";
		key_event(8'h1C, 1'b0, 1'b0, 1'b0);
		wait_drain();
		key_event(8'h1C, 1'b1, 1'b0, 1'b0);
		key_event(8'h16, 1'b0, 1'b0, 1'b0);
		key_event(8'h29, 1'b0, 1'b0, 1'b0);
		key_event(8'h29, 1'b1, 1'b0, 1'b0);
		wait_drain();
		check_count("press_count", model_count, press_count);

		test_name = "extended";
		key_event(8'h75, 1'b0, 1'b1, 1'b0);
		key_event(8'h75, 1'b1, 1'b1, 1'b0);
		key_event(8'h5A, 1'b0, 1'b1, 1'b0);
		key_event(8'h05, 1'b0, 1'b0, 1'b0);
		key_event(8'h05, 1'b1, 1'b0, 1'b0);
		wait_drain();

		test_name = "repeat";
		for (i = 0; i < 4; i++)
			key_event(8'h24, 1'b0, 1'b0, 1'b0);
		wait_drain();
		check_count("press_count", model_count, press_count);
		key_event(8'h24, 1'b0, 1'b1, 1'b0);
		wait_drain();
		check_count("press_count", model_count, press_count);

		// Full lap of the counter
		test_name = "count_wrap";
		for (i = 0; i < (1 << `KBD_COUNT_W); i++) begin
			key_event(i[0] ? 8'h32 : 8'h1C, 1'b0, 1'b0, 1'b0);
			wait_drain();
		end
		check_count("press_count", model_count, press_count);

		test_name = "bad_frame";
		errs_before = frame_err_seen;
		send_byte(8'h2B, 1'b1, 1'b0);
		check_flag("frame_error pulse", 1'b1, frame_err_seen == errs_before + 1);
		send_byte(8'h34, 1'b0, 1'b1);
		check_flag("frame_error pulse", 1'b1, frame_err_seen == errs_before + 2);
		key_event(8'h2B, 1'b0, 1'b0, 1'b0);
		wait_drain();
		check_count("press_count", model_count, press_count);

		test_name = "random";
		prev_stall = 1'b0;
		for (i = 0; i < 40; i++) begin
			kind  = $unsigned($random(seed)) % 4;
			code  = pick_code();
			ext   = (($random(seed) & 3) == 0);
			// Never two stalls in a row, so the queue cannot fill
			stall = !prev_stall && (($random(seed) & 3) == 0);
			credit_en = !stall;
			case (kind)
				0: key_event(code, 1'b0, ext, 1'b0);
				1: begin
					n = 2 + ($unsigned($random(seed)) % 3);
					repeat (n) key_event(code, 1'b0, ext, 1'b0);
				end
				2: begin
					key_event(code, 1'b0, ext, 1'b0);
					key_event(code, 1'b1, ext, 1'b0);
				end
				default: key_event(code, 1'b1, ext, 1'b0);
			endcase
			check_count("press_count", model_count, press_count);
			if (!stall) wait_drain();
			prev_stall = stall;
		end
		credit_en = 1'b1;
		wait_drain();

		test_name = "overflow";
		key_event(8'h05, 1'b0, 1'b0, 1'b0);
		wait_drain();
		check_flag("overflow", 1'b0, overflow);
		credit_en = 1'b0;
		for (i = 0; i < `KBD_QUEUE_DEPTH + `KBD_CREDITS + 2; i++)
			key_event(letter_codes[i], 1'b0, 1'b0, i >= `KBD_QUEUE_DEPTH + `KBD_CREDITS);
		check_flag("overflow", 1'b1, overflow);
		check_count("press_count", model_count, press_count);
		credit_en = 1'b1;
		wait_drain();
		check_flag("overflow", 1'b1, overflow);

		wait_cycles(50);
		if (exp_q.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/kbd_pkg.sv
src/kbd_event_if.sv
src/ps2_frame_rx.sv
src/scancode_decoder.sv
src/ascii_map.sv
src/kbd_ctrl.sv
src/ps2_kbd_top.sv
bench/tb_clk_gen.sv
bench/tb_ps2_kbd.sv

// File: Bender.yml
package:
  name: ps2_kbd

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/kbd_pkg.sv
      - src/kbd_event_if.sv
      - src/ps2_frame_rx.sv
      - src/scancode_decoder.sv
      - src/ascii_map.sv
      - src/kbd_ctrl.sv
      - src/ps2_kbd_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_ps2_kbd.sv
